// ==== common/memory_macros.svh ====
`ifndef MEMORY_MACROS_SVH
`define MEMORY_MACROS_SVH

// Host bus geometry
`define MEM_DATA_W 16
`define MEM_ADDR_W 14

`define NUM_SEGMENT 2

// Per-region address and data widths
`define CTL_ADDR_W 8
`define CLK_ADDR_W 7
`define DUTY_IDX_W 15
`define MOD_IDX_W 14
`define STM_ADDR_W 10
`define STM_PAGE_W 4
`define STM_DATA_W 64

// Special controller addresses
`define ADDR_MOD_WR_SEGMENT 8'h20
`define ADDR_STM_WR_SEGMENT 8'h21
`define ADDR_STM_WR_PAGE 8'h22
`define ADDR_DUTY_WR_PAGE 8'h23
`define ADDR_MOD_CYCLE 8'h24

// Values of host addr[13:8] inside the controller region
`define CNT_SEL_MAIN 6'd0
`define CNT_SEL_CLOCK 6'd1

`endif

// ==== common/host_bus_pkg.sv ====
`default_nettype none

`include "memory_macros.svh"

package host_bus_pkg;

  // One host word and one host address
  typedef logic [`MEM_DATA_W-1:0] host_data_t;
  typedef logic [`MEM_ADDR_W-1:0] host_addr_t;

  // Region chosen by the host bus
  typedef enum logic [1:0] {
    sel_controller = 2'd0,
    sel_mod        = 2'd1,
    sel_duty_table = 2'd2,
    sel_stm        = 2'd3
  } bram_select_e;

  // Host-side memory bus that writes on en and we
  typedef struct packed {
    logic         en;
    logic         we;
    bram_select_e select;
    host_addr_t   addr;
    host_data_t   din;
  } host_bus_t;

endpackage

`default_nettype wire

// ==== common/array_data_pkg.sv ====
`default_nettype none

`include "memory_macros.svh"

package array_data_pkg;

  typedef logic segment_t;

  // Modulation memory with 8-bit samples
  typedef logic [`MOD_IDX_W-1:0] mod_idx_t;
  typedef logic [7:0] mod_value_t;

  // Duty table page bit sits just above the host address bits
  typedef logic [15:0] duty_idx_t;
  typedef logic [7:0] duty_value_t;

  // STM words with the page prefixed to the word address
  typedef logic [`STM_ADDR_W-1:0] stm_addr_t;
  typedef logic [`STM_DATA_W-1:0] stm_value_t;

  // Controller and clock table words share the host width
  typedef logic [`MEM_DATA_W-1:0] ctl_data_t;
  typedef logic [`CTL_ADDR_W-1:0] ctl_addr_t;
  typedef logic [`CLK_ADDR_W-1:0] clk_addr_t;

  // Array-side controller RAM port
  typedef struct packed {
    logic      we;
    ctl_addr_t addr;
    ctl_data_t din;
  } ctl_port_t;

  // Array-side clock table port
  typedef struct packed {
    logic      we;
    clk_addr_t addr;
    ctl_data_t din;
  } clk_port_t;

endpackage

`default_nettype wire

// ==== design/dp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 8
) (
  input  wire logic              bus_clk,
  input  wire logic              a_en,
  input  wire logic              a_we,
  input  wire logic [ADDR_W-1:0] a_addr,
  input  wire logic [DATA_W-1:0] a_din,
  output logic      [DATA_W-1:0] a_dout,
  input  wire logic              b_en,
  input  wire logic              b_we,
  input  wire logic [ADDR_W-1:0] b_addr,
  input  wire logic [DATA_W-1:0] b_din,
  output logic      [DATA_W-1:0] b_dout
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // Both ports share one clock, so one process owns the array
  always_ff @(posedge bus_clk) begin
    if (a_en && a_we) begin
      mem[a_addr] <= a_din;
    end
    if (b_en && b_we) begin
      mem[b_addr] <= b_din;
    end
    // Write-first on each port
    if (a_en) begin
      a_dout <= a_we ? a_din : mem[a_addr];
    end
    if (b_en) begin
      b_dout <= b_we ? b_din : mem[b_addr];
    end
  end

endmodule

`default_nettype wire

// ==== memory/wr_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memory_macros.svh"

module wr_config_regs (
  input  wire logic                        bus_clk,
  input  wire logic                        rst_n,
  input  wire logic                        ctl_wr,
  input  wire host_bus_pkg::host_addr_t    addr,
  input  wire host_bus_pkg::host_data_t    din,
  output array_data_pkg::segment_t         mod_wr_segment,
  output array_data_pkg::segment_t         stm_wr_segment,
  output logic [`STM_PAGE_W-1:0]           stm_wr_page,
  output logic                             duty_wr_page
);

  logic [2:0] wr_hist;
  host_bus_pkg::host_addr_t addr_q;
  host_bus_pkg::host_data_t din_q;

  // Address and data of the second strobe cycle
  always_ff @(posedge bus_clk) begin
    addr_q <= addr;
    din_q  <= din;
  end

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      wr_hist        <= '0;
      mod_wr_segment <= '0;
      stm_wr_segment <= '0;
      stm_wr_page    <= '0;
      duty_wr_page   <= 1'b0;
    end else begin
      wr_hist <= {wr_hist[1:0], ctl_wr};
      // Low then two highs marks a held write
      if (wr_hist == 3'b011) begin
        case (addr_q)
          host_bus_pkg::host_addr_t'(`ADDR_MOD_WR_SEGMENT): mod_wr_segment <= din_q[0];
          host_bus_pkg::host_addr_t'(`ADDR_STM_WR_SEGMENT): stm_wr_segment <= din_q[0];
          host_bus_pkg::host_addr_t'(`ADDR_STM_WR_PAGE):
            stm_wr_page <= din_q[`STM_PAGE_W-1:0];
          host_bus_pkg::host_addr_t'(`ADDR_DUTY_WR_PAGE): duty_wr_page <= din_q[0];
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== memory/memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memory_macros.svh"

module memory (
  input  wire logic                        bus_clk,
  input  wire logic                        rst_n,
  input  wire host_bus_pkg::host_bus_t     host_bus,
  output host_bus_pkg::host_data_t         host_dout,
  input  wire array_data_pkg::ctl_port_t   ctl_port,
  output array_data_pkg::ctl_data_t        ctl_dout,
  input  wire array_data_pkg::clk_port_t   clk_port,
  output array_data_pkg::ctl_data_t        clk_dout,
  input  wire array_data_pkg::duty_idx_t   duty_idx,
  output array_data_pkg::duty_value_t      duty_value,
  input  wire array_data_pkg::mod_idx_t    mod_idx,
  input  wire array_data_pkg::segment_t    mod_segment,
  output array_data_pkg::mod_value_t       mod_value,
  input  wire array_data_pkg::stm_addr_t   stm_addr,
  input  wire array_data_pkg::segment_t    stm_segment,
  output array_data_pkg::stm_value_t       stm_value
);

  logic [5:0] cnt_sel;
  logic ctl_en;
  logic clk_en;
  logic duty_en;
  logic stm_wr;
  logic stm_commit;
  logic ctl_rd_q;
  host_bus_pkg::host_data_t ctl_host_dout;

  array_data_pkg::segment_t mod_wr_segment;
  array_data_pkg::segment_t stm_wr_segment;
  logic [`STM_PAGE_W-1:0] stm_wr_page;
  logic duty_wr_page;

  // Three lower 16-bit lanes of the STM word being assembled
  logic [`STM_DATA_W-`MEM_DATA_W-1:0] stm_stage;
  array_data_pkg::stm_addr_t stm_wr_addr;

  array_data_pkg::mod_value_t mod_rd [`NUM_SEGMENT];
  array_data_pkg::stm_value_t stm_rd [`NUM_SEGMENT];

  assign cnt_sel = host_bus.addr[13:8];

  // Region decode
  assign ctl_en = host_bus.en && host_bus.select == host_bus_pkg::sel_controller &&
                  cnt_sel == `CNT_SEL_MAIN;
  assign clk_en = host_bus.en && host_bus.select == host_bus_pkg::sel_controller &&
                  cnt_sel == `CNT_SEL_CLOCK;
  assign duty_en = host_bus.en && host_bus.select == host_bus_pkg::sel_duty_table;

  wr_config_regs u_wr_config_regs (
    .bus_clk       (bus_clk),
    .rst_n         (rst_n),
    .ctl_wr        (ctl_en && host_bus.we),
    .addr          (host_bus.addr),
    .din           (host_bus.din),
    .mod_wr_segment(mod_wr_segment),
    .stm_wr_segment(stm_wr_segment),
    .stm_wr_page   (stm_wr_page),
    .duty_wr_page  (duty_wr_page)
  );

  // Host reads only the main controller RAM
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      ctl_rd_q <= 1'b0;
    end else begin
      ctl_rd_q <= ctl_en;
    end
  end

  assign host_dout = ctl_rd_q ? ctl_host_dout : '0;

  dp_ram #(.DATA_W(`MEM_DATA_W), .ADDR_W(`CTL_ADDR_W)) u_ctl_ram (
    .bus_clk(bus_clk),
    .a_en   (ctl_en),
    .a_we   (host_bus.we),
    .a_addr (host_bus.addr[`CTL_ADDR_W-1:0]),
    .a_din  (host_bus.din),
    .a_dout (ctl_host_dout),
    .b_en   (1'b1),
    .b_we   (ctl_port.we),
    .b_addr (ctl_port.addr),
    .b_din  (ctl_port.din),
    .b_dout (ctl_dout)
  );

  dp_ram #(.DATA_W(`MEM_DATA_W), .ADDR_W(`CLK_ADDR_W)) u_clk_ram (
    .bus_clk(bus_clk),
    .a_en   (clk_en),
    .a_we   (host_bus.we),
    .a_addr (host_bus.addr[`CLK_ADDR_W-1:0]),
    .a_din  (host_bus.din),
    .a_dout (),
    .b_en   (1'b1),
    .b_we   (clk_port.we),
    .b_addr (clk_port.addr),
    .b_din  (clk_port.din),
    .b_dout (clk_dout)
  );

  // Host writes the page selected by the page register
  dp_ram #(.DATA_W(8), .ADDR_W(`DUTY_IDX_W)) u_duty_ram (
    .bus_clk(bus_clk),
    .a_en   (duty_en),
    .a_we   (host_bus.we),
    .a_addr ({duty_wr_page, host_bus.addr}),
    .a_din  (host_bus.din[7:0]),
    .a_dout (),
    .b_en   (1'b1),
    .b_we   (1'b0),
    .b_addr (duty_idx[`DUTY_IDX_W-1:0]),
    .b_din  (8'h00),
    .b_dout (duty_value)
  );

  // STM host address lanes 0 to 2 are staged, lane 3 commits the word
  assign stm_wr = host_bus.en && host_bus.we && host_bus.select == host_bus_pkg::sel_stm;
  assign stm_commit = stm_wr && host_bus.addr[1:0] == 2'd3;
  assign stm_wr_addr = {stm_wr_page, host_bus.addr[`STM_ADDR_W-`STM_PAGE_W+1:2]};

  always_ff @(posedge bus_clk) begin
    if (stm_wr && !stm_commit) begin
      stm_stage[host_bus.addr[1:0]*`MEM_DATA_W +: `MEM_DATA_W] <= host_bus.din;
    end
  end

  for (genvar i = 0; i < `NUM_SEGMENT; i++) begin : gen_segment
    dp_ram #(.DATA_W(8), .ADDR_W(`MOD_IDX_W)) u_mod_ram (
      .bus_clk(bus_clk),
      .a_en   (host_bus.en && host_bus.select == host_bus_pkg::sel_mod &&
               mod_wr_segment == i),
      .a_we   (host_bus.we),
      .a_addr (host_bus.addr),
      .a_din  (host_bus.din[7:0]),
      .a_dout (),
      .b_en   (1'b1),
      .b_we   (1'b0),
      .b_addr (mod_idx),
      .b_din  (8'h00),
      .b_dout (mod_rd[i])
    );

    dp_ram #(.DATA_W(`STM_DATA_W), .ADDR_W(`STM_ADDR_W)) u_stm_ram (
      .bus_clk(bus_clk),
      .a_en   (stm_commit && stm_wr_segment == i),
      .a_we   (1'b1),
      .a_addr (stm_wr_addr),
      .a_din  ({host_bus.din, stm_stage}),
      .a_dout (),
      .b_en   (1'b1),
      .b_we   (1'b0),
      .b_addr (stm_addr),
      .b_din  ('0),
      .b_dout (stm_rd[i])
    );
  end

  // Segment picked after the RAM output registers
  assign mod_value = mod_rd[mod_segment];
  assign stm_value = stm_rd[stm_segment];

endmodule

`default_nettype wire

// ==== design/mod_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memory_macros.svh"

module mod_sampler (
  input  wire logic                        bus_clk,
  input  wire logic                        rst_n,
  input  wire logic                        update_tick,
  input  wire array_data_pkg::segment_t    mod_segment,
  output array_data_pkg::ctl_port_t        ctl_port,
  input  wire array_data_pkg::ctl_data_t   ctl_dout,
  output array_data_pkg::mod_idx_t         mod_idx,
  input  wire array_data_pkg::mod_value_t  mod_raw,
  output array_data_pkg::mod_value_t       mod_value,
  output logic                             mod_valid
);

  logic refresh_phase;
  array_data_pkg::mod_idx_t mod_cycle;
  array_data_pkg::segment_t last_segment;
  logic [1:0] tick_pipe;

  // Read-only access to the cycle length register
  assign ctl_port.we   = 1'b0;
  assign ctl_port.addr = `ADDR_MOD_CYCLE;
  assign ctl_port.din  = '0;

  // RAM output refreshes every cycle and is latched every other one
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      refresh_phase <= 1'b0;
      mod_cycle     <= '0;
    end else begin
      refresh_phase <= ~refresh_phase;
      if (refresh_phase) begin
        mod_cycle <= ctl_dout[`MOD_IDX_W-1:0];
      end
    end
  end

  // Index runs 0..mod_cycle and restarts at 0 on a segment switch
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      mod_idx      <= '0;
      last_segment <= '0;
    end else if (update_tick) begin
      last_segment <= mod_segment;
      if (mod_segment != last_segment || mod_idx >= mod_cycle) begin
        mod_idx <= '0;
      end else begin
        mod_idx <= mod_idx + array_data_pkg::mod_idx_t'(1);
      end
    end
  end

  // Two stages for the index register and the RAM read
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      tick_pipe <= '0;
      mod_valid <= 1'b0;
    end else begin
      tick_pipe <= {tick_pipe[0], update_tick};
      mod_valid <= tick_pipe[1];
    end
  end

  always_ff @(posedge bus_clk) begin
    if (tick_pipe[1]) begin
      mod_value <= mod_raw;
    end
  end

endmodule

`default_nettype wire

// ==== design/array_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module array_mem_top (
  input  wire logic                        bus_clk,
  input  wire logic                        rst_n,
  input  wire host_bus_pkg::host_bus_t     host_bus,
  output host_bus_pkg::host_data_t         host_dout,
  input  wire logic                        update_tick,
  input  wire array_data_pkg::segment_t    mod_segment,
  output array_data_pkg::mod_value_t       mod_value,
  output logic                             mod_valid,
  input  wire array_data_pkg::clk_port_t   clk_port,
  output array_data_pkg::ctl_data_t        clk_dout,
  input  wire array_data_pkg::duty_idx_t   duty_idx,
  output array_data_pkg::duty_value_t      duty_value,
  input  wire array_data_pkg::stm_addr_t   stm_addr,
  input  wire array_data_pkg::segment_t    stm_segment,
  output array_data_pkg::stm_value_t       stm_value
);

  // Sampler to memory
  array_data_pkg::ctl_port_t ctl_port;
  array_data_pkg::ctl_data_t ctl_dout;
  array_data_pkg::mod_idx_t mod_idx;
  array_data_pkg::mod_value_t mod_raw;

  memory u_memory (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .host_bus   (host_bus),
    .host_dout  (host_dout),
    .ctl_port   (ctl_port),
    .ctl_dout   (ctl_dout),
    .clk_port   (clk_port),
    .clk_dout   (clk_dout),
    .duty_idx   (duty_idx),
    .duty_value (duty_value),
    .mod_idx    (mod_idx),
    .mod_segment(mod_segment),
    .mod_value  (mod_raw),
    .stm_addr   (stm_addr),
    .stm_segment(stm_segment),
    .stm_value  (stm_value)
  );

  mod_sampler u_mod_sampler (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .update_tick(update_tick),
    .mod_segment(mod_segment),
    .ctl_port   (ctl_port),
    .ctl_dout   (ctl_dout),
    .mod_idx    (mod_idx),
    .mod_raw    (mod_raw),
    .mod_value  (mod_value),
    .mod_valid  (mod_valid)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic bus_clk
);

  // Free-running clock that starts low
  initial begin
    bus_clk = 1'b0;
    forever begin
      #(PERIOD / 2);
      bus_clk = ~bus_clk;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_array_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_array_mem;

  localparam int TIMEOUT_CYCLES = 20;
  // Cycles from the tick edge to the mod_valid edge
  localparam int MOD_LATENCY = 2;

  logic                          bus_clk;
  logic                          rst_n;
  host_bus_pkg::host_bus_t       host_bus;
  host_bus_pkg::host_data_t      host_dout;
  logic                          update_tick;
  array_data_pkg::segment_t      mod_segment;
  array_data_pkg::mod_value_t    mod_value;
  logic                          mod_valid;
  array_data_pkg::clk_port_t     clk_port;
  array_data_pkg::ctl_data_t     clk_dout;
  array_data_pkg::duty_idx_t     duty_idx;
  array_data_pkg::duty_value_t   duty_value;
  array_data_pkg::stm_addr_t     stm_addr;
  array_data_pkg::segment_t      stm_segment;
  array_data_pkg::stm_value_t    stm_value;

  int check_count;
  int fail_count;
  int test_checks;
  int test_fails;
  logic timed_out;
  logic [31:0] lcg_state;
  // STM words written so far, by data file slot
  array_data_pkg::stm_value_t stm_slot [16];
  string test_name [8];

  tb_clock_gen #(.PERIOD(100)) u_clock_gen (.bus_clk(bus_clk));

  array_mem_top uut (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .host_bus   (host_bus),
    .host_dout  (host_dout),
    .update_tick(update_tick),
    .mod_segment(mod_segment),
    .mod_value  (mod_value),
    .mod_valid  (mod_valid),
    .clk_port   (clk_port),
    .clk_dout   (clk_dout),
    .duty_idx   (duty_idx),
    .duty_value (duty_value),
    .stm_addr   (stm_addr),
    .stm_segment(stm_segment),
    .stm_value  (stm_value)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    test_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      fail_count++;
      test_fails++;
    end
  endtask

  // Strobe held for hold cycles, then one idle cycle
  task automatic host_write(input logic [1:0] sel, input logic [13:0] addr,
                            input logic [15:0] data, input int hold);
    host_bus.en     = 1'b1;
    host_bus.we     = 1'b1;
    host_bus.select = host_bus_pkg::bram_select_e'(sel);
    host_bus.addr   = addr;
    host_bus.din    = data;
    repeat (hold) @(negedge bus_clk);
    host_bus = '0;
    @(negedge bus_clk);
  endtask

  task automatic host_read(input logic [1:0] sel, input logic [13:0] addr,
                           input logic [15:0] exp);
    host_bus.en     = 1'b1;
    host_bus.we     = 1'b0;
    host_bus.select = host_bus_pkg::bram_select_e'(sel);
    host_bus.addr   = addr;
    host_bus.din    = '0;
    @(negedge bus_clk);
    host_bus = '0;
    check_value("host_dout", 64'(host_dout), 64'(exp));
    @(negedge bus_clk);
  endtask

  task automatic stm_write(input logic [13:0] base, input logic [3:0] slot);
    array_data_pkg::stm_value_t word;
    lcg_state = lcg_next(lcg_state);
    word[63:32] = lcg_state;
    lcg_state = lcg_next(lcg_state);
    word[31:0] = lcg_state;
    stm_slot[slot] = word;
    // Lanes 0 to 2 are staged, lane 3 commits
    for (int lane = 0; lane < 4; lane++) begin
      host_write(2'd3, base + 14'(lane), word[16*lane +: 16], 1);
    end
  endtask

  task automatic mod_tick(input logic seg, input logic [7:0] exp);
    int wait_cycles;
    mod_segment = seg;
    update_tick = 1'b1;
    @(negedge bus_clk);
    update_tick = 1'b0;
    wait_cycles = 0;
    while (!mod_valid && wait_cycles < TIMEOUT_CYCLES) begin
      @(negedge bus_clk);
      wait_cycles++;
    end
    if (!mod_valid) begin
      $display("Timeout: mod_valid did not rise after update_tick at %0t", $time);
      timed_out = 1'b1;
    end else begin
      check_value("mod_valid latency", 64'(wait_cycles), 64'(MOD_LATENCY));
      check_value("mod_value", 64'(mod_value), 64'(exp));
    end
    @(negedge bus_clk);
    // One tick gives a single valid cycle
    check_value("mod_valid", 64'(mod_valid), 64'd0);
  endtask

  task automatic finish_test(input logic [2:0] id);
    $display("test %0d %s: %0d checks, %0d failures", id, test_name[id],
             test_checks, test_fails);
    test_checks = 0;
    test_fails  = 0;
  endtask

  task automatic run_record(input logic [31:0] op, input logic [31:0] sel,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp);
    case (op)
      32'h0: host_write(sel[1:0], addr[13:0], data[15:0], 1);
      32'h1: host_write(sel[1:0], addr[13:0], data[15:0], 2);
      32'h2: host_read(sel[1:0], addr[13:0], exp[15:0]);
      32'h3: begin
        clk_port.we   = 1'b0;
        clk_port.addr = addr[6:0];
        clk_port.din  = '0;
        @(negedge bus_clk);
        check_value("clk_dout", 64'(clk_dout), 64'(exp[15:0]));
      end
      32'h4: begin
        duty_idx = addr[15:0];
        @(negedge bus_clk);
        check_value("duty_value", 64'(duty_value), 64'(exp[7:0]));
      end
      32'h5: mod_tick(sel[0], exp[7:0]);
      32'h6: stm_write(addr[13:0], data[3:0]);
      32'h7: begin
        stm_segment = sel[0];
        stm_addr    = addr[9:0];
        @(negedge bus_clk);
        check_value("stm_value", stm_value, stm_slot[data[3:0]]);
      end
      32'hf: finish_test(addr[2:0]);
      default: begin
        $display("Unknown operation code %0h in the data file", op);
        fail_count++;
      end
    endcase
  endtask

  initial begin
    int fd;
    int code;
    int ch;
    logic done;
    logic [31:0] op;
    logic [31:0] sel;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    test_name = '{"", "controller ram", "clock table", "duty paging", "mod sampling",
                  "stm segment and page", "short strobe", ""};
    rst_n       = 1'b0;
    host_bus    = '0;
    update_tick = 1'b0;
    mod_segment = 1'b0;
    clk_port    = '0;
    duty_idx    = '0;
    stm_addr    = '0;
    stm_segment = 1'b0;
    check_count = 0;
    fail_count  = 0;
    test_checks = 0;
    test_fails  = 0;
    timed_out   = 1'b0;
    lcg_state   = 32'd87;
    done        = 1'b0;
    repeat (16) @(negedge bus_clk);
    rst_n = 1'b1;
    @(negedge bus_clk);

    fd = $fopen("verif/testdata_mem.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/testdata_mem.txt");
      fail_count++;
      done = 1'b1;
    end
    while (!done && !timed_out) begin
      code = $fscanf(fd, "%h %h %h %h %h", op, sel, addr, data, exp);
      if (code == 5) begin
        run_record(op, sel, addr, data, exp);
      end else if (code > 0) begin
        $display("Incomplete record in the data file after %0d checks", check_count);
        fail_count++;
        done = 1'b1;
      end else if ($feof(fd)) begin
        done = 1'b1;
      end else begin
        // Skip a comment line to its end
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
        if (ch == -1) begin
          done = 1'b1;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("total: %0d checks, %0d failures", check_count, fail_count);
    if (fail_count == 0 && !timed_out && check_count > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/testdata_mem.txt ====
# op sel addr data expect, all hex. op: 0 write, 1 held write, 2 host read, 3 clock read,
# 4 duty read, 5 mod tick (sel = segment), 6 stm write (data = slot), 7 stm read, f end test
0 0 0005 1234 0000
0 0 0010 abcd 0000
0 0 00ff 5a5a 0000
2 0 0005 0000 1234
2 0 0010 0000 abcd
2 0 00ff 0000 5a5a
f 0 0001 0000 0000
0 0 0103 0f0f 0000
0 0 017f 8001 0000
3 0 0003 0000 0f0f
3 0 007f 0000 8001
2 0 0103 0000 0000
f 0 0002 0000 0000
0 2 0040 0011 0000
1 0 0023 0001 0000
0 2 0040 0022 0000
4 0 0040 0000 0011
4 0 4040 0000 0022
2 0 0023 0000 0001
f 0 0003 0000 0000
0 0 0024 0003 0000
0 1 0000 0010 0000
0 1 0001 0011 0000
0 1 0002 0012 0000
0 1 0003 0013 0000
1 0 0020 0001 0000
0 1 0000 0020 0000
0 1 0001 0021 0000
0 1 0002 0022 0000
0 1 0003 0023 0000
5 0 0000 0000 0011
5 0 0000 0000 0012
5 0 0000 0000 0013
5 0 0000 0000 0010
5 0 0000 0000 0011
5 1 0000 0000 0020
5 1 0000 0000 0021
5 1 0000 0000 0022
5 1 0000 0000 0023
5 1 0000 0000 0020
f 0 0004 0000 0000
6 3 0014 0000 0000
1 0 0022 0003 0000
6 3 0014 0001 0000
1 0 0021 0001 0000
6 3 0014 0002 0000
1 0 0022 0000 0000
6 3 0008 0003 0000
7 0 0005 0000 0000
7 0 00c5 0001 0000
7 1 00c5 0002 0000
7 1 0002 0003 0000
f 0 0005 0000 0000
0 0 0023 0000 0000
0 2 0040 0044 0000
4 0 4040 0000 0044
4 0 0040 0000 0011
2 0 0023 0000 0000
f 0 0006 0000 0000

// ==== filelist.f ====
+incdir+common
common/host_bus_pkg.sv
common/array_data_pkg.sv
design/dp_ram.sv
memory/wr_config_regs.sv
memory/memory.sv
design/mod_sampler.sv
design/array_mem_top.sv
verif/tb_clock_gen.sv
verif/tb_array_mem.sv

// ==== Makefile ====
VERILATOR    ?= verilator
TOP          := tb_array_mem
FILELIST     := filelist.f
OBJ_DIR      := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS   := --lint-only -Wall
SIM_FLAGS    := --binary --assert -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
